//--- Makefile
SIM        ?= verilator
TOP        ?= wiscCoreTb
FILELIST   ?= wiscCore.f
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert

.PHONY: lint sim clean

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- design/controlUnit.sv
/*
 * instruction decoder
 * maps opcode and function code to the control word
 * flags undefined opcodes on err
 */
module controlUnit (
   input  wiscPkg::instrU instr,
   ctrlIf.decoder         ctrl,
   output logic           err
);

   // arith code is func or the low opcode bits
   function automatic wiscPkg::aluOpT arithOp(input logic [1:0] code);
      case (code)
         2'b00:   return wiscPkg::aluAdd;
         2'b01:   return wiscPkg::aluSub;
         2'b10:   return wiscPkg::aluXor;
         default: return wiscPkg::aluAndn;
      endcase
   endfunction

   // shift code uses the same layout
   function automatic wiscPkg::aluOpT shiftOp(input logic [1:0] code);
      case (code)
         2'b00:   return wiscPkg::aluRol;
         2'b01:   return wiscPkg::aluSll;
         2'b10:   return wiscPkg::aluRor;
         default: return wiscPkg::aluSrl;
      endcase
   endfunction

   always_comb begin
      // quiet defaults write nothing
      ctrl.regWrt  = 1'b0;
      ctrl.regDst  = wiscPkg::dstRdI;
      ctrl.bSrc    = wiscPkg::bReg;
      ctrl.zeroExt = 1'b0;
      ctrl.stuSel  = 1'b0;
      ctrl.aluOp   = wiscPkg::aluAdd;
      ctrl.brch    = wiscPkg::brNone;
      ctrl.memWrt  = 1'b0;
      ctrl.memRd   = 1'b0;
      ctrl.wbSel   = wiscPkg::wbAlu;
      ctrl.halt    = 1'b0;
      err          = 1'b0;
      case (instr.iForm.opcode)
         wiscPkg::opHalt: ctrl.halt = 1'b1;
         wiscPkg::opAddi, wiscPkg::opSubi, wiscPkg::opXori, wiscPkg::opAndni: begin
            ctrl.regWrt  = 1'b1;
            ctrl.bSrc    = wiscPkg::bImm5;
            ctrl.zeroExt = instr.iForm.opcode[1]; // xori, andni zero extend
            ctrl.aluOp   = arithOp(instr.iForm.opcode[1:0]);
         end
         wiscPkg::opRoli, wiscPkg::opSlli, wiscPkg::opRori, wiscPkg::opSrli: begin
            ctrl.regWrt  = 1'b1;
            ctrl.bSrc    = wiscPkg::bImm5;
            ctrl.zeroExt = 1'b1;
            ctrl.aluOp   = shiftOp(instr.iForm.opcode[1:0]);
         end
         wiscPkg::opAlu, wiscPkg::opShift: begin
            ctrl.regWrt = 1'b1;
            ctrl.regDst = wiscPkg::dstRdR;
            ctrl.aluOp  = instr.rForm.opcode[0] ? arithOp(instr.rForm.func)
                                                : shiftOp(instr.rForm.func);
         end
         wiscPkg::opLbi, wiscPkg::opSlbi: begin
            ctrl.regWrt  = 1'b1;
            ctrl.regDst  = wiscPkg::dstRs;
            ctrl.bSrc    = wiscPkg::bImm8;
            ctrl.zeroExt = instr.bForm.opcode[3] ? 1'b0 : 1'b1; // slbi ors in unsigned byte
            ctrl.aluOp   = instr.bForm.opcode[3] ? wiscPkg::aluPassB : wiscPkg::aluSlbi;
         end
         wiscPkg::opSt, wiscPkg::opStu: begin
            ctrl.bSrc   = wiscPkg::bImm5;
            ctrl.memWrt = 1'b1;
            ctrl.stuSel = 1'b1;
            ctrl.regWrt = instr.iForm.opcode[1]; // stu updates rs with the address
            ctrl.regDst = wiscPkg::dstRs;
         end
         wiscPkg::opLd: begin
            ctrl.regWrt = 1'b1;
            ctrl.bSrc   = wiscPkg::bImm5;
            ctrl.memRd  = 1'b1;
            ctrl.wbSel  = wiscPkg::wbMem;
         end
         wiscPkg::opBeqz, wiscPkg::opBnez: begin
            ctrl.bSrc = wiscPkg::bImm8;
            ctrl.brch = instr.bForm.opcode[0] ? wiscPkg::brBnez : wiscPkg::brBeqz;
         end
         wiscPkg::opJ, wiscPkg::opJal: begin
            ctrl.bSrc   = wiscPkg::bImm11;
            ctrl.brch   = wiscPkg::brJmp;
            ctrl.regWrt = instr.jForm.opcode[1]; // jal links to r7
            ctrl.regDst = wiscPkg::dstR7;
            ctrl.wbSel  = wiscPkg::wbPc2;
         end
         default: begin
            err       = 1'b1; // undefined opcode stops the core
            ctrl.halt = 1'b1;
         end
      endcase
   end

   // a load and a store never share one instruction
   assert property (@(posedge ctrl.clk) !(ctrl.memWrt && ctrl.memRd));

endmodule

//--- design/ctrlIf.sv
/*
 * control word from the instruction decoder
 * decoder drives it, decode stage and execute stage read their parts
 */
interface ctrlIf (
   input logic clk
);
   // consumed in decode
   logic             regWrt;  // register file write
   wiscPkg::regDstT  regDst;  // destination register select
   wiscPkg::bSrcT    bSrc;    // alu operand B source
   logic             zeroExt; // zero extend imm5/imm8
   logic             stuSel;  // store data from the rt/rd register

   // consumed in execute / memory
   wiscPkg::aluOpT   aluOp;
   wiscPkg::brchT    brch;
   logic             memWrt;
   logic             memRd;
   wiscPkg::wbSelT   wbSel;
   logic             halt;    // halt or illegal opcode

   modport decoder (
      input  clk,
      output regWrt, regDst, bSrc, zeroExt, stuSel,
      output aluOp, brch, memWrt, memRd, wbSel, halt
   );

   modport decode (input regWrt, regDst, bSrc, zeroExt, stuSel);

   modport exec (input aluOp, brch, memWrt, memRd, wbSel, halt);

endinterface

//--- design/decodeStage.sv
/*
 * decode stage
 * immediate extension, destination and operand B select,
 * store data select and the register file
 */
`include "wisc_defs.svh"

module decodeStage (
   input  logic                     clk,
   input  logic                     rstN,
   input  wiscPkg::instrU           instr,
   input  logic [`WISC_DATA_W-1:0]  wbData,
   input  logic                     wbEn,    // instruction commits this cycle
   ctrlIf.decode                    ctrl,
   output logic [`WISC_DATA_W-1:0]  opA,
   output logic [`WISC_DATA_W-1:0]  opB,
   output logic [`WISC_DATA_W-1:0]  storeData,
   output logic [`WISC_DATA_W-1:0]  imm,     // branch / jump displacement
   output logic [`WISC_REG_AW-1:0]  wrReg,
   output logic                     wrEn
);

   localparam int W = `WISC_DATA_W;

   logic [W-1:0] imm5;
   logic [W-1:0] imm8;
   logic [W-1:0] imm11;
   logic [W-1:0] regB;

   // zero or sign extension as the decoder asks
   assign imm5 = ctrl.zeroExt ? {{(W-5){1'b0}}, instr.iForm.imm}
                              : {{(W-5){instr.iForm.imm[4]}}, instr.iForm.imm};
   assign imm8 = ctrl.zeroExt ? {{(W-8){1'b0}}, instr.bForm.imm}
                              : {{(W-8){instr.bForm.imm[7]}}, instr.bForm.imm};
   assign imm11 = {{(W-11){instr.jForm.disp[10]}}, instr.jForm.disp}; // always signed

   always_comb begin
      case (ctrl.regDst)
         wiscPkg::dstRdI: wrReg = instr.iForm.rd;
         wiscPkg::dstRdR: wrReg = instr.rForm.rd;
         wiscPkg::dstRs:  wrReg = instr.iForm.rs;
         default:         wrReg = `WISC_REG_AW'(`WISC_REG_N - 1); // r7 link
      endcase
   end

   assign wrEn = wbEn & ctrl.regWrt;

   regFile regs (
      .clk     (clk),
      .rstN    (rstN),
      .rdSelA  (instr.iForm.rs),
      .rdSelB  (instr.rForm.rt), // same bits as rd of the i-format
      .wrSel   (wrReg),
      .wrData  (wbData),
      .wrEn    (wrEn),
      .rdDataA (opA),
      .rdDataB (regB)
   );

   always_comb begin
      case (ctrl.bSrc)
         wiscPkg::bReg:  opB = regB;
         wiscPkg::bImm5: opB = imm5;
         wiscPkg::bImm8: opB = imm8;
         default:        opB = imm11;
      endcase
   end

   assign imm       = (ctrl.bSrc == wiscPkg::bImm11) ? imm11 : imm8; // j/jal vs branch
   assign storeData = ctrl.stuSel ? regB : opB; // st/stu write the [7:5] register

endmodule

//--- design/executeMemory.sv
/*
 * execute and memory stage
 * alu, branch condition, next pc, data memory, writeback select
 */
`include "wisc_defs.svh"

module executeMemory (
   input  logic                     clk,
   input  logic                     run,
   input  logic                     halted,
   input  logic [`WISC_DATA_W-1:0]  pc,
   input  logic [`WISC_DATA_W-1:0]  opA,
   input  logic [`WISC_DATA_W-1:0]  opB,
   input  logic [`WISC_DATA_W-1:0]  storeData,
   input  logic [`WISC_DATA_W-1:0]  imm,
   ctrlIf.exec                      ctrl,
   output logic [`WISC_DATA_W-1:0]  nextPc,
   output logic [`WISC_DATA_W-1:0]  wbData,
   output logic                     wbEn,
   output logic                     stop,
   output logic                     memWe,
   output logic [`WISC_DATA_W-1:0]  memAddr,
   output logic [`WISC_DATA_W-1:0]  memWrData
);

   localparam int W = `WISC_DATA_W;

   logic [W-1:0]   dmem [`WISC_DMEM_DEPTH];
   logic [W-1:0]   aluOut;
   logic [W-1:0]   rdData;
   logic [W-1:0]   pcPlus2;
   logic [W-1:0]   target;
   logic [2*W-1:0] rotL;
   logic [2*W-1:0] rotR;
   logic [3:0]     shAmt;
   logic           active;
   logic           taken;

   assign active = run & ~halted; // instruction commits this cycle
   assign shAmt  = opB[3:0];
   assign rotL   = {opA, opA} << shAmt; // upper half is the rotate
   assign rotR   = {opA, opA} >> shAmt; // lower half is the rotate

   always_comb begin
      case (ctrl.aluOp)
         wiscPkg::aluAdd:   aluOut = opA + opB; // also load/store address
         wiscPkg::aluSub:   aluOut = opB - opA;
         wiscPkg::aluXor:   aluOut = opA ^ opB;
         wiscPkg::aluAndn:  aluOut = opA & ~opB;
         wiscPkg::aluRol:   aluOut = rotL[2*W-1:W];
         wiscPkg::aluSll:   aluOut = opA << shAmt;
         wiscPkg::aluRor:   aluOut = rotR[W-1:0];
         wiscPkg::aluSrl:   aluOut = opA >> shAmt;
         wiscPkg::aluPassB: aluOut = opB; // lbi
         wiscPkg::aluSlbi:  aluOut = {opA[W-9:0], opB[7:0]};
         default:           aluOut = '0;
      endcase
   end

   // branch resolution, condition on rs only
   always_comb begin
      case (ctrl.brch)
         wiscPkg::brBeqz:   taken = (opA == '0);
         wiscPkg::brBnez:   taken = (opA != '0);
         wiscPkg::brJmp,
         wiscPkg::brJmpReg: taken = 1'b1;
         default:           taken = 1'b0;
      endcase
   end

   assign pcPlus2 = pc + W'(2);
   assign target  = (ctrl.brch == wiscPkg::brJmpReg) ? opA + imm : pcPlus2 + imm;
   assign nextPc  = taken ? target : pcPlus2;

   // word-wide data memory, no reset
   assign memAddr   = aluOut;
   assign memWrData = storeData;
   assign memWe     = active & ctrl.memWrt;

   always_ff @(posedge clk) begin
      if (memWe) begin
         dmem[memAddr[`WISC_DMEM_AW:1]] <= memWrData;
      end
   end

   assign rdData = ctrl.memRd ? dmem[memAddr[`WISC_DMEM_AW:1]] : '0;

   always_comb begin
      case (ctrl.wbSel)
         wiscPkg::wbMem: wbData = rdData;
         wiscPkg::wbPc2: wbData = pcPlus2; // jal link
         default:        wbData = aluOut;  // stu gets its address here
      endcase
   end

   assign wbEn = active;
   assign stop = active & ctrl.halt;

   // once stopped the fetch latch holds and memory stays untouched
   assert property (@(posedge clk) stop |=> halted && !memWe);

endmodule

//--- design/fetchStage.sv
/*
 * fetch stage
 * program counter, instruction memory with load port, halt latch
 */
`include "wisc_defs.svh"

module fetchStage (
   input  logic                      clk,
   input  logic                      rstN,
   input  logic                      run,
   input  logic                      progWe,   // one-cycle load strobe
   input  logic [`WISC_IMEM_AW-1:0]  progAddr, // word index
   input  logic [`WISC_DATA_W-1:0]   progData,
   input  logic [`WISC_DATA_W-1:0]   nextPc,
   input  logic                      stop,     // halt or err this cycle
   output wiscPkg::instrU            instr,
   output logic [`WISC_DATA_W-1:0]   pc,
   output logic                      halted
);

   logic [`WISC_DATA_W-1:0] imem [`WISC_IMEM_DEPTH];

   // program load, no back-pressure
   always_ff @(posedge clk) begin
      if (progWe) begin
         imem[progAddr] <= progData;
      end
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         pc     <= '0;
         halted <= 1'b0;
      end else begin
         if (stop) begin
            halted <= 1'b1; // sticky until reset
         end
         // pc stays on the halting instruction
         if (run && !halted && !stop) begin
            pc <= nextPc;
         end
      end
   end

   // byte pc, word memory
   // idle core sees opcode 0 so the decoder stays quiet during the load
   assign instr = run ? imem[pc[`WISC_IMEM_AW:1]] : '0;

endmodule

//--- design/regFile.sv
/*
 * general purpose register file
 * eight registers, two async read ports, one write port
 */
`include "wisc_defs.svh"

module regFile (
   input  logic                     clk,
   input  logic                     rstN,
   input  logic [`WISC_REG_AW-1:0]  rdSelA,
   input  logic [`WISC_REG_AW-1:0]  rdSelB,
   input  logic [`WISC_REG_AW-1:0]  wrSel,
   input  logic [`WISC_DATA_W-1:0]  wrData,
   input  logic                     wrEn,
   output logic [`WISC_DATA_W-1:0]  rdDataA,
   output logic [`WISC_DATA_W-1:0]  rdDataB
);

   logic [`WISC_DATA_W-1:0] regs [`WISC_REG_N];

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         for (int i = 0; i < `WISC_REG_N; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn) begin
         regs[wrSel] <= wrData;
      end
   end

   // reads return the value committed at the last edge
   assign rdDataA = regs[rdSelA];
   assign rdDataB = regs[rdSelB];

   // destination must resolve whenever a write commits
   assert property (@(posedge clk) disable iff (!rstN) wrEn |-> !$isunknown(wrSel));

endmodule

//--- design/wiscCore.sv
/*
 * core top level
 * fetch, decoder, decode and execute/memory stages with the control bus
 */
`include "wisc_defs.svh"

module wiscCore (
   input  logic                      clk,
   input  logic                      rstN,
   input  logic                      run,
   input  logic                      progWe,
   input  logic [`WISC_IMEM_AW-1:0]  progAddr,
   input  logic [`WISC_DATA_W-1:0]   progData,
   output logic                      wbValid,
   output logic [`WISC_REG_AW-1:0]   wbReg,
   output logic [`WISC_DATA_W-1:0]   wbData,
   output logic                      memWe,
   output logic [`WISC_DATA_W-1:0]   memAddr,
   output logic [`WISC_DATA_W-1:0]   memWrData,
   output logic                      halted,
   output logic                      err
);

   wiscPkg::instrU          instr;
   logic [`WISC_DATA_W-1:0] pc;
   logic [`WISC_DATA_W-1:0] nextPc;
   logic [`WISC_DATA_W-1:0] opA;
   logic [`WISC_DATA_W-1:0] opB;
   logic [`WISC_DATA_W-1:0] storeData;
   logic [`WISC_DATA_W-1:0] imm;
   logic                    wbEn;
   logic                    stop;

   ctrlIf ctrlBus (.clk(clk));

   fetchStage fetch (
      .clk(clk), .rstN(rstN), .run(run), .progWe(progWe), .progAddr(progAddr),
      .progData(progData), .nextPc(nextPc), .stop(stop),
      .instr(instr), .pc(pc), .halted(halted)
   );

   controlUnit decoder (.instr(instr), .ctrl(ctrlBus.decoder), .err(err));

   decodeStage decode (
      .clk(clk), .rstN(rstN), .instr(instr), .wbData(wbData), .wbEn(wbEn),
      .ctrl(ctrlBus.decode), .opA(opA), .opB(opB), .storeData(storeData), .imm(imm),
      .wrReg(wbReg), .wrEn(wbValid)
   );

   executeMemory execMem (
      .clk(clk), .run(run), .halted(halted), .pc(pc), .opA(opA), .opB(opB),
      .storeData(storeData), .imm(imm), .ctrl(ctrlBus.exec), .nextPc(nextPc),
      .wbData(wbData), .wbEn(wbEn), .stop(stop), .memWe(memWe), .memAddr(memAddr),
      .memWrData(memWrData)
   );

endmodule

//--- design/wiscPkg.sv
/*
 * shared types of the core
 * opcode enum, instruction union and its four formats
 * alu op, operand B, destination, writeback and branch selectors
 */
package wiscPkg;

   // major opcode, instr[15:11]
   typedef enum logic [4:0] {
      opHalt  = 5'b00000,
      opJ     = 5'b00100,
      opJal   = 5'b00110,
      opAddi  = 5'b01000,
      opSubi  = 5'b01001,
      opXori  = 5'b01010,
      opAndni = 5'b01011,
      opBeqz  = 5'b01100,
      opBnez  = 5'b01101,
      opSt    = 5'b10000,
      opLd    = 5'b10001,
      opSlbi  = 5'b10010,
      opStu   = 5'b10011,
      opRoli  = 5'b10100,
      opSlli  = 5'b10101,
      opRori  = 5'b10110,
      opSrli  = 5'b10111,
      opLbi   = 5'b11000,
      opShift = 5'b11010, // rol/sll/ror/srl, func in [1:0]
      opAlu   = 5'b11011  // add/sub/xor/andn, func in [1:0]
   } opcodeT;

   typedef struct packed {
      opcodeT     opcode;
      logic [2:0] rs;
      logic [2:0] rd;
      logic [4:0] imm;
   } iFormT;

   typedef struct packed {
      opcodeT     opcode;
      logic [2:0] rs;
      logic [2:0] rt;
      logic [2:0] rd;
      logic [1:0] func;
   } rFormT;

   typedef struct packed {
      opcodeT      opcode;
      logic [10:0] disp;
   } jFormT;

   // lbi, slbi and branches
   typedef struct packed {
      opcodeT     opcode;
      logic [2:0] rs;
      logic [7:0] imm;
   } bFormT;

   typedef union packed {
      iFormT iForm;
      rFormT rForm;
      jFormT jForm;
      bFormT bForm;
   } instrU;

   typedef enum logic [3:0] {
      aluAdd, aluSub, aluXor, aluAndn, aluRol, aluSll, aluRor, aluSrl, aluPassB, aluSlbi
   } aluOpT;

   typedef enum logic [1:0] {bReg, bImm5, bImm8, bImm11} bSrcT;

   typedef enum logic [1:0] {dstRdI, dstRdR, dstRs, dstR7} regDstT;

   typedef enum logic [1:0] {wbAlu, wbMem, wbPc2} wbSelT;

   typedef enum logic [2:0] {brNone, brBeqz, brBnez, brJmp, brJmpReg} brchT;

endpackage

//--- include/wisc_defs.svh
/*
 * sizing macros for the 16-bit core
 * data width, register count, memory depths and address widths
 */
`ifndef WISC_DEFS_SVH
`define WISC_DEFS_SVH

// datapath and instruction word
`define WISC_DATA_W 16

// register file
`define WISC_REG_N 8
`define WISC_REG_AW 3

// instruction memory, word index is pc[8:1]
`define WISC_IMEM_DEPTH 256
`define WISC_IMEM_AW 8

// data memory, word index is addr[8:1]
`define WISC_DMEM_DEPTH 256
`define WISC_DMEM_AW 8

`endif

//--- tb/wiscCoreTb.sv
/*
 * testbench for the core
 * random programs with forward-only control flow
 * architectural model that builds the expected per-cycle trace
 */
`include "wisc_defs.svh"

module wiscCoreTb;

   localparam int W        = `WISC_DATA_W;
   localparam int progLen  = 60;           // random instructions before the terminator
   localparam int haltWait = 20;           // cycles allowed for halted to rise
   localparam int baseSeed = 32'h048ad110;

   // what the core shows while one instruction executes
   typedef struct packed {
      logic                    wbValid;
      logic [`WISC_REG_AW-1:0] wbReg;
      logic [W-1:0]            wbData;
      logic                    memWe;
      logic [W-1:0]            memAddr;
      logic [W-1:0]            memWrData;
   } stepT;

   logic                     clk;
   logic                     rstN;
   logic                     run;
   logic                     progWe;
   logic [`WISC_IMEM_AW-1:0] progAddr;
   logic [W-1:0]             progData;
   logic                     wbValid;
   logic [`WISC_REG_AW-1:0]  wbReg;
   logic [W-1:0]             wbData;
   logic                     memWe;
   logic [W-1:0]             memAddr;
   logic [W-1:0]             memWrData;
   logic                     halted;
   logic                     err;

   // model state, data memory survives reset like the real one
   logic [W-1:0] prog [progLen+1];
   logic [W-1:0] regs [`WISC_REG_N];
   logic [W-1:0] dmem [`WISC_DMEM_DEPTH];
   bit           stored [`WISC_DMEM_DEPTH]; // words written so far
   stepT         trace [$];
   int           seed;

   // opcodes the generator draws from
   wiscPkg::opcodeT opList [19] = '{
      wiscPkg::opAddi, wiscPkg::opSubi, wiscPkg::opXori, wiscPkg::opAndni,
      wiscPkg::opRoli, wiscPkg::opSlli, wiscPkg::opRori, wiscPkg::opSrli,
      wiscPkg::opAlu, wiscPkg::opShift, wiscPkg::opLbi, wiscPkg::opSlbi,
      wiscPkg::opSt, wiscPkg::opStu, wiscPkg::opLd,
      wiscPkg::opBeqz, wiscPkg::opBnez, wiscPkg::opJ, wiscPkg::opJal
   };

   wiscCore wiscCore_inst (
      .clk(clk), .rstN(rstN), .run(run), .progWe(progWe), .progAddr(progAddr),
      .progData(progData), .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
      .memWe(memWe), .memAddr(memAddr), .memWrData(memWrData), .halted(halted), .err(err)
   );

   always #2 clk = ~clk;

   task automatic failRun(input string why);
      $display("%s", why);
      $display("Simulation failed");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check(input string name, input logic [W-1:0] actual,
                        input logic [W-1:0] expected);
      if (actual !== expected) begin
         failRun($sformatf("ERR %s got 0x%h expected 0x%h", name, actual, expected));
      end
   endtask

   // nothing may commit while the core is idle
   task automatic checkIdle();
      check("wbValid", W'(wbValid), '0);
      check("memWe", W'(memWe), '0);
      check("halted", W'(halted), '0);
      check("err", W'(err), '0);
   endtask

   function automatic logic [31:0] randBits();
      return $random(seed);
   endfunction

   // isa result: arith group add/sub/xor/andn, shift group rol/sll/ror/srl
   function automatic logic [W-1:0] aluRef(input bit isShift, input logic [1:0] code,
                                           input logic [W-1:0] a, input logic [W-1:0] b);
      logic [3:0] n;
      n = b[3:0];
      if (isShift) begin
         case (code)
            2'd0:    return (a << n) | (a >> (W - n));
            2'd1:    return a << n;
            2'd2:    return (a >> n) | (a << (W - n));
            default: return a >> n;
         endcase
      end
      case (code)
         2'd0:    return a + b;
         2'd1:    return b - a; // rs is the subtrahend
         2'd2:    return a ^ b;
         default: return a & ~b;
      endcase
   endfunction

   function automatic stepT wbStep(input logic [`WISC_REG_AW-1:0] r, input logic [W-1:0] d);
      stepT s;
      s         = '0;
      s.wbValid = 1'b1;
      s.wbReg   = r;
      s.wbData  = d;
      return s;
   endfunction

   // generate one program and run the model along the path it takes
   task automatic buildProgram(input bit illegalEnd);
      wiscPkg::instrU ins;
      stepT           step;
      logic [W-1:0]   a;
      logic [W-1:0]   b;
      logic [W-1:0]   imm5s;
      logic [W-1:0]   addr;
      int             pcIdx;
      int             k;
      int             pick;
      int             tries;
      bit             found;
      pcIdx = 0;
      trace.delete();
      for (int r = 0; r < `WISC_REG_N; r++) begin
         regs[r] = '0;
      end
      for (int i = 0; i < progLen; i++) begin
         ins = W'(randBits());
         k   = int'(randBits() % 19);
         ins.iForm.opcode = opList[k];
         // forward only, landing at most on the terminator
         case (ins.iForm.opcode)
            wiscPkg::opBeqz, wiscPkg::opBnez: ins.bForm.imm = 8'(2 * (randBits() % (progLen - i)));
            wiscPkg::opJ, wiscPkg::opJal:     ins.jForm.disp = 11'(2 * (randBits() % (progLen - i)));
            default: ;
         endcase
         if (pcIdx == i) begin
            if (ins.iForm.opcode == wiscPkg::opLd) begin // only read words written before
               found = 1'b0;
               pick  = int'(randBits() % 256);
               for (tries = 0; tries < 256 && !found; tries++) begin
                  ins.iForm.rs  = 3'((pick + tries) >> 5);
                  ins.iForm.imm = 5'(pick + tries);
                  addr  = regs[ins.iForm.rs] + {{(W-5){ins.iForm.imm[4]}}, ins.iForm.imm};
                  found = stored[addr[`WISC_DMEM_AW:1]];
               end
               if (!found) begin
                  ins.iForm.opcode = wiscPkg::opSt;
               end
            end
            a     = regs[ins.iForm.rs];
            b     = regs[ins.rForm.rt]; // also the store data register
            imm5s = {{(W-5){ins.iForm.imm[4]}}, ins.iForm.imm};
            step  = '0;
            pcIdx = i + 1;
            case (ins.iForm.opcode)
               wiscPkg::opAddi, wiscPkg::opSubi:
                  step = wbStep(ins.iForm.rd, aluRef(1'b0, ins.iForm.opcode[1:0], a, imm5s));
               wiscPkg::opXori, wiscPkg::opAndni: // unsigned immediate
                  step = wbStep(ins.iForm.rd,
                                aluRef(1'b0, ins.iForm.opcode[1:0], a, W'(ins.iForm.imm)));
               wiscPkg::opRoli, wiscPkg::opSlli, wiscPkg::opRori, wiscPkg::opSrli:
                  step = wbStep(ins.iForm.rd,
                                aluRef(1'b1, ins.iForm.opcode[1:0], a, W'(ins.iForm.imm)));
               wiscPkg::opAlu, wiscPkg::opShift:
                  step = wbStep(ins.rForm.rd, aluRef(!ins.rForm.opcode[0], ins.rForm.func, a, b));
               wiscPkg::opLbi:
                  step = wbStep(ins.bForm.rs, {{(W-8){ins.bForm.imm[7]}}, ins.bForm.imm});
               wiscPkg::opSlbi:
                  step = wbStep(ins.bForm.rs, {a[7:0], ins.bForm.imm});
               wiscPkg::opSt, wiscPkg::opStu: begin
                  step = (ins.iForm.opcode == wiscPkg::opStu) ? wbStep(ins.iForm.rs, a + imm5s)
                                                              : '0;
                  step.memWe     = 1'b1;
                  step.memAddr   = a + imm5s;
                  step.memWrData = b;
               end
               wiscPkg::opLd: begin
                  addr = a + imm5s;
                  step = wbStep(ins.iForm.rd, dmem[addr[`WISC_DMEM_AW:1]]);
               end
               wiscPkg::opBeqz: if (a == '0) pcIdx += int'(ins.bForm.imm) / 2;
               wiscPkg::opBnez: if (a != '0) pcIdx += int'(ins.bForm.imm) / 2;
               wiscPkg::opJ:    pcIdx += int'(ins.jForm.disp) / 2;
               wiscPkg::opJal: begin
                  step  = wbStep(3'd7, W'(2 * i + 2)); // link is the byte pc of the next word
                  pcIdx += int'(ins.jForm.disp) / 2;
               end
               default: ;
            endcase
            if (step.wbValid) begin
               regs[step.wbReg] = step.wbData;
            end
            if (step.memWe) begin
               dmem[step.memAddr[`WISC_DMEM_AW:1]]   = step.memWrData;
               stored[step.memAddr[`WISC_DMEM_AW:1]] = 1'b1;
            end
            trace.push_back(step);
         end
         prog[i] = ins;
      end
      // terminator cycle writes nothing, 00001 is not a defined opcode
      prog[progLen] = illegalEnd ? {5'b00001, 11'h000} : '0;
      trace.push_back('0);
   endtask

   task automatic runProgram(input bit illegalEnd);
      stepT exp;
      int   n;
      @(negedge clk);
      run  = 1'b0;
      rstN = 1'b0;
      repeat (4) @(negedge clk);
      rstN = 1'b1;
      for (int i = 0; i <= progLen; i++) begin
         progWe   = 1'b1;
         progAddr = `WISC_IMEM_AW'(i);
         progData = prog[i];
         #1; // sample a quarter period after the falling edge
         checkIdle();
         @(negedge clk);
      end
      progWe = 1'b0;
      run    = 1'b1;
      for (int c = 0; c < trace.size(); c++) begin
         #1;
         exp = trace[c];
         check("wbValid", W'(wbValid), W'(exp.wbValid));
         if (exp.wbValid) begin
            check("wbReg", W'(wbReg), W'(exp.wbReg));
            check("wbData", wbData, exp.wbData);
         end
         check("memWe", W'(memWe), W'(exp.memWe));
         if (exp.memWe) begin
            check("memAddr", memAddr, exp.memAddr);
            check("memWrData", memWrData, exp.memWrData);
         end
         check("halted", W'(halted), '0);
         check("err", W'(err), W'(illegalEnd && (c == trace.size() - 1)));
         @(negedge clk);
      end
      n = 0;
      while (!halted && n < haltWait) begin
         @(negedge clk);
         n++;
      end
      if (!halted) begin
         failRun("timeout, halted never rose after the last instruction");
      end
      // frozen core, nothing commits
      repeat (10) begin
         #1;
         check("wbValid", W'(wbValid), '0);
         check("memWe", W'(memWe), '0);
         check("halted", W'(halted), W'(1'b1));
         check("err", W'(err), W'(illegalEnd));
         @(negedge clk);
      end
   endtask

   initial begin
      clk      = 1'b0;
      rstN     = 1'b0;
      run      = 1'b0;
      progWe   = 1'b0;
      progAddr = '0;
      progData = '0;
      for (int p = 0; p < 3; p++) begin
         seed = baseSeed + p * 32'h0101;
         buildProgram(p == 2); // last program ends on an undefined opcode
         runProgram(p == 2);
      end
      $display("Simulation completed successfully");
      $finish;
   end

endmodule

//--- wiscCore.f
+incdir+include
design/wiscPkg.sv
design/ctrlIf.sv
design/controlUnit.sv
design/regFile.sv
design/decodeStage.sv
design/fetchStage.sv
design/executeMemory.sv
design/wiscCore.sv
tb/wiscCoreTb.sv
